/* sim.f */
logic/vdp_pkg.sv
logic/vdp_host_if.sv
logic/vdp_mem_if.sv
logic/vdp_bus_port.sv
logic/vdp_cmd_engine.sv
logic/vdp_vram.sv
logic/vdp_backdrop.sv
logic/vdp_top.sv
test/vdp_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the VDP testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f sim.f --top-module vdp_tb -o vdp_sim; then
  echo "Verilator build failed"
  exit 1
fi

output="$(./obj_dir/vdp_sim)"
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "=== PASS ==="; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* test/vdp_stimulus.txt */
# W adr data | R adr expected name | C red green blue name   (all values hex)
# W and R are Wishbone writes and reads, C polls the backdrop RGB outputs
W BF 20
W BF 41
W BE 11
W BE 22
W BE 33
W BF 20
W BF 01
R BE 11 vram_rd0
R BE 22 vram_rd1
R BE 33 vram_rd2
W BF FF
W BF 7F
W BE A5
W BE 5A
W BF FF
W BF 3F
R BE A5 wrap_hi
R BE 5A wrap_lo
W BF 10
W BF C0
W BE DE
W BE DF
W BE E0
W BE E1
W BF 00
W BF 87
C A F 5 backdrop16
W BF 01
W BF 87
C F F 5 backdrop17
W BF 02
W BF 87
C 0 0 A backdrop18
W BF 03
W BF 87
C 5 0 A backdrop19
W BF 00
W BF 42
W BE C1
W BE C2
W BE C3
W BF 00
W BF 02
W BF 80
R BE C1 toggle_rd
W BF 02
W BF 02
R BE C3 toggle_cmd
W BF 0C
W BF 83
C 5 0 A reg3_ignored
W BF 20
W BF 01
W 7E 99
R BE 11 foreign_wr0
R BE 22 foreign_wr1
R 7E 00 foreign_rd

/* test/vdp_tb.sv */
`timescale 1ns/100ps

module vdp_tb;

  localparam int TIMEOUT = 50;  // Cycles allowed per wait

  logic              clk = 1'b0;
  logic              rst_L;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  vdp_pkg::io_adr_t  wb_adr;
  vdp_pkg::byte_t    wb_dat_i;
  vdp_pkg::byte_t    wb_dat_o;
  logic              wb_ack;
  vdp_pkg::channel_t backdrop_r;
  vdp_pkg::channel_t backdrop_g;
  vdp_pkg::channel_t backdrop_b;
  logic [31:0]       lfsr_q = 32'hc25d_305e;  // Idle gap source

  vdp_top u_vdp_top (.*);

  always #2 clk = ~clk;

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  // Galois form with a 32-bit maximal-length mask
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    lfsr_step = state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  task automatic fail_run(input string why);
    $display("%0s", why);
    $display("=== FAIL ===");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_byte(input string name, input vdp_pkg::byte_t exp, act);
    if (act !== exp)
      fail_run($sformatf("Mismatch %0s: expected %02h, actual %02h", name, exp, act));
  endtask

  task automatic check_channel(input string name, input vdp_pkg::channel_t exp, act);
    if (act !== exp)
      fail_run($sformatf("Mismatch %0s: expected %0h, actual %0h", name, exp, act));
  endtask

  // Two LFSR bits per gap give 0 to 3 idle cycles
  task automatic idle_gap();
    logic [1:0] gap;
    gap[0] = lfsr_q[0];
    lfsr_q = lfsr_step(lfsr_q);
    gap[1] = lfsr_q[0];
    lfsr_q = lfsr_step(lfsr_q);
    repeat (gap) @(posedge clk);
  endtask

  // One classic cycle with stb held until ack
  task automatic bus_access(input logic we, input vdp_pkg::io_adr_t adr,
                            input vdp_pkg::byte_t dat, output vdp_pkg::byte_t rdata);
    int waited;
    waited = 0;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_i <= dat;
    do begin
      @(negedge clk);  // ack and read data are stable mid-cycle
      waited++;
    end while (!wb_ack && waited < TIMEOUT);
    if (!wb_ack) fail_run($sformatf("No acknowledge came from I/O address %02h", adr));
    rdata = wb_dat_o;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  // Colour output trails the register or CRAM write by a couple of cycles
  task automatic poll_backdrop(input string name, input vdp_pkg::channel_t r, g, b);
    int waited;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while ({backdrop_r, backdrop_g, backdrop_b} !== {r, g, b} && waited < TIMEOUT);
    check_channel({name, " red"}, r, backdrop_r);
    check_channel({name, " green"}, g, backdrop_g);
    check_channel({name, " blue"}, b, backdrop_b);
  endtask

  // --------------------------------------------------------------------------
  // Stimulus file replay
  // --------------------------------------------------------------------------
  initial begin
    int                fd;
    string             line;
    string             name;
    vdp_pkg::io_adr_t  adr;
    vdp_pkg::byte_t    dat;
    vdp_pkg::byte_t    rdata;
    vdp_pkg::channel_t exp_r;
    vdp_pkg::channel_t exp_g;
    vdp_pkg::channel_t exp_b;
    rst_L    <= 1'b0;
    wb_cyc   <= 1'b0;
    wb_stb   <= 1'b0;
    wb_we    <= 1'b0;
    wb_adr   <= '0;
    wb_dat_i <= '0;
    fd = $fopen("test/vdp_stimulus.txt", "r");
    if (fd == 0) fail_run("Could not open test/vdp_stimulus.txt");
    repeat (4) @(posedge clk);
    rst_L <= 1'b1;
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line.getc(0) == "#") continue;  // Blank or column notes
      idle_gap();
      case (line.getc(0))
        "W": begin
          if ($sscanf(line, "W %h %h", adr, dat) != 2)
            fail_run($sformatf("Malformed stimulus line %0s", line));
          bus_access(1'b1, adr, dat, rdata);
        end
        "R": begin
          if ($sscanf(line, "R %h %h %s", adr, dat, name) != 3)
            fail_run($sformatf("Malformed stimulus line %0s", line));
          bus_access(1'b0, adr, 8'h00, rdata);
          check_byte(name, dat, rdata);
        end
        "C": begin
          if ($sscanf(line, "C %h %h %h %s", exp_r, exp_g, exp_b, name) != 4)
            fail_run($sformatf("Malformed stimulus line %0s", line));
          poll_backdrop(name, exp_r, exp_g, exp_b);
        end
        default: fail_run($sformatf("Unknown stimulus line %0s", line));
      endcase
    end
    $fclose(fd);
    $display("=== PASS ===");
    $finish;
  end

endmodule : vdp_tb

/* logic/vdp_top.sv */
`timescale 1ns/100ps

module vdp_top (
  input  logic              clk,
  input  logic              rst_L,

  // --------------------------------------------------------------------------
  // Wishbone classic slave, I/O ports BE (data) and BF (control)
  // --------------------------------------------------------------------------
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  logic              wb_we,
  input  vdp_pkg::io_adr_t  wb_adr,
  input  vdp_pkg::byte_t    wb_dat_i,
  output vdp_pkg::byte_t    wb_dat_o,
  output logic              wb_ack,

  // Backdrop colour
  output vdp_pkg::channel_t backdrop_r,
  output vdp_pkg::channel_t backdrop_g,
  output vdp_pkg::channel_t backdrop_b
);

  vdp_host_if host_if ();
  vdp_mem_if  mem_if ();

  vdp_bus_port u_bus_port (
    .clk,
    .rst_L,
    .wb_cyc,
    .wb_stb,
    .wb_we,
    .wb_adr,
    .wb_dat_i,
    .wb_dat_o,
    .wb_ack,
    .host (host_if.bus)
  );

  vdp_cmd_engine u_cmd_engine (
    .clk,
    .rst_L,
    .host (host_if.engine),
    .mem  (mem_if.engine)
  );

  vdp_vram u_vram (
    .clk,
    .mem (mem_if.vram)
  );

  vdp_backdrop u_backdrop (
    .clk,
    .rst_L,
    .mem (mem_if.palette),
    .backdrop_r,
    .backdrop_g,
    .backdrop_b
  );

endmodule : vdp_top

/* logic/vdp_backdrop.sv */
`timescale 1ns/100ps

module vdp_backdrop (
  input  logic              clk,
  input  logic              rst_L,
  vdp_mem_if.palette        mem,
  output vdp_pkg::channel_t backdrop_r,
  output vdp_pkg::channel_t backdrop_g,
  output vdp_pkg::channel_t backdrop_b
);

  vdp_pkg::color_t    cram [0:31];
  vdp_pkg::cram_adr_t rd_adr;
  vdp_pkg::color_t    entry_q;

  // 2-bit level to 4-bit channel: 0, 5, 10, 15
  function automatic vdp_pkg::channel_t color_step(input logic [1:0] level);
    color_step = {level, level};
  endfunction

  // --------------------------------------------------------------------------
  // CRAM, written from the data port
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (mem.cram_we) begin
      cram[mem.cram_adr] <= mem.cram_wdata;
    end
  end

  assign rd_adr = {vdp_pkg::BACKDROP_BANK, mem.backdrop_idx};  // Entries 16..31

  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      entry_q <= '0;
    end else begin
      entry_q <= cram[rd_adr];
    end
  end

  // --------------------------------------------------------------------------
  // Expansion to RGB
  // --------------------------------------------------------------------------
  assign backdrop_r = color_step(entry_q[1:0]);
  assign backdrop_g = color_step(entry_q[3:2]);
  assign backdrop_b = color_step(entry_q[5:4]);

endmodule : vdp_backdrop

/* logic/vdp_vram.sv */
`timescale 1ns/100ps

// 16K x 8 VRAM, single port.
// Maps onto one block RAM with output register
module vdp_vram (
  input logic     clk,
  vdp_mem_if.vram mem
);

  vdp_pkg::byte_t ram [0:16383];
  vdp_pkg::byte_t rdata_q;

  always_ff @(posedge clk) begin
    if (mem.vram_we) begin
      ram[mem.vram_adr] <= mem.vram_wdata;
    end
  end

  // Read data one cycle after re, held otherwise
  always_ff @(posedge clk) begin
    if (mem.vram_re) begin
      rdata_q <= ram[mem.vram_adr];
    end
  end

  assign mem.vram_rdata = rdata_q;

endmodule : vdp_vram

/* logic/vdp_cmd_engine.sv */
`timescale 1ns/100ps

module vdp_cmd_engine (
  input  logic       clk,
  input  logic       rst_L,
  vdp_host_if.engine host,
  vdp_mem_if.engine  mem
);

  typedef enum logic [2:0] {IDLE, PREFETCH, READ_WAIT, READ_FILL, REPLY} state_t;

  state_t             state, next_state;
  vdp_pkg::byte_t     first_q;     // First control byte
  logic               toggle_q;    // Waiting for the second byte
  vdp_pkg::vram_adr_t addr_q;
  vdp_pkg::cmd_op_t   op_q;
  vdp_pkg::byte_t     read_buf_q;
  vdp_pkg::byte_t     rdata_q;
  logic [3:0]         reg7_q;

  logic               cmd_byte;
  logic               second_byte;
  logic               data_wr;
  logic               data_rd;
  logic               prefetch_start;
  vdp_pkg::vram_adr_t cmd_addr;
  vdp_pkg::cmd_op_t   cmd_op;

  // --------------------------------------------------------------------------
  // Request decode, only accepted in IDLE
  // --------------------------------------------------------------------------
  assign cmd_byte    = (state == IDLE) && host.req && host.ctrl && host.we;
  assign second_byte = cmd_byte && toggle_q;
  assign data_wr     = (state == IDLE) && host.req && !host.ctrl && host.we;
  assign data_rd     = (state == IDLE) && host.req && !host.ctrl && !host.we;

  assign cmd_addr = {host.wdata[5:0], first_q};
  assign cmd_op   = vdp_pkg::cmd_op_t'(host.wdata[7:6]);

  // Read command fetches the first byte right away, off the new address
  assign prefetch_start = second_byte && (cmd_op == vdp_pkg::OP_VRAM_READ);

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (prefetch_start) next_state = PREFETCH;
        else if (data_rd) next_state = READ_WAIT;
        else if (host.req) next_state = REPLY;
      end
      PREFETCH:  next_state = IDLE;
      READ_WAIT: next_state = READ_FILL;
      READ_FILL: next_state = IDLE;
      REPLY:     next_state = IDLE;
      default:   next_state = IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      state      <= IDLE;
      first_q    <= '0;
      toggle_q   <= 1'b0;
      addr_q     <= '0;
      op_q       <= vdp_pkg::OP_VRAM_READ;
      read_buf_q <= '0;
      reg7_q     <= '0;
    end else begin
      state <= next_state;

      if (cmd_byte && !toggle_q) first_q <= host.wdata;

      if (cmd_byte) toggle_q <= !toggle_q;
      else if (data_wr || data_rd) toggle_q <= 1'b0;  // Data port resets the pair

      if (second_byte) begin
        addr_q <= cmd_addr;
        op_q   <= cmd_op;
      end else if (data_wr || state == PREFETCH || state == READ_FILL) begin
        addr_q <= addr_q + 1'b1;  // Wraps at 3FFF
      end

      if (state == PREFETCH || state == READ_FILL) read_buf_q <= mem.vram_rdata;

      // Only register 7 is kept
      if (second_byte && cmd_op == vdp_pkg::OP_REG_WRITE &&
          host.wdata[3:0] == vdp_pkg::BACKDROP_REG) begin
        reg7_q <= first_q[3:0];
      end
    end
  end

  // Data reads return the buffer as it was before the refill
  always_ff @(posedge clk) begin
    if (state == IDLE && host.req) rdata_q <= data_rd ? read_buf_q : '0;
  end

  assign host.done  = (state == REPLY) || (state == PREFETCH) || (state == READ_FILL);
  assign host.rdata = rdata_q;

  // --------------------------------------------------------------------------
  // Memory side
  // --------------------------------------------------------------------------
  assign mem.vram_adr   = prefetch_start ? cmd_addr : addr_q;
  assign mem.vram_re    = prefetch_start || (state == READ_WAIT);
  assign mem.vram_we    = data_wr && (op_q != vdp_pkg::OP_CRAM_WRITE);
  assign mem.vram_wdata = host.wdata;

  assign mem.cram_adr   = addr_q[4:0];
  assign mem.cram_we    = data_wr && (op_q == vdp_pkg::OP_CRAM_WRITE);
  assign mem.cram_wdata = host.wdata[5:0];

  assign mem.backdrop_idx = reg7_q;

endmodule : vdp_cmd_engine

/* logic/vdp_bus_port.sv */
`timescale 1ns/100ps

module vdp_bus_port (
  input  logic             clk,
  input  logic             rst_L,
  input  logic             wb_cyc,
  input  logic             wb_stb,
  input  logic             wb_we,
  input  vdp_pkg::io_adr_t wb_adr,
  input  vdp_pkg::byte_t   wb_dat_i,
  output vdp_pkg::byte_t   wb_dat_o,
  output logic             wb_ack,
  vdp_host_if.bus          host
);

  typedef enum logic [1:0] {IDLE, ISSUE, WAIT_DONE, ACK} state_t;

  state_t         state, next_state;
  logic           vdp_q;   // Access hits BE or BF
  logic           ctrl_q;
  logic           we_q;
  vdp_pkg::byte_t dat_q;

  always_comb begin
    next_state = state;
    case (state)
      IDLE:      if (wb_cyc && wb_stb) next_state = ISSUE;
      ISSUE:     next_state = vdp_q ? WAIT_DONE : ACK;  // Foreign ports ack locally
      WAIT_DONE: if (host.done) next_state = ACK;
      ACK:       next_state = IDLE;
      default:   next_state = IDLE;
    endcase
  end

  // Decode is sampled once per access, master holds adr until ack
  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      state  <= IDLE;
      vdp_q  <= 1'b0;
      ctrl_q <= 1'b0;
      we_q   <= 1'b0;
    end else begin
      state <= next_state;
      if (state == IDLE && wb_cyc && wb_stb) begin
        vdp_q  <= (wb_adr == vdp_pkg::DATA_PORT_ADR) || (wb_adr == vdp_pkg::CTRL_PORT_ADR);
        ctrl_q <= (wb_adr == vdp_pkg::CTRL_PORT_ADR);
        we_q   <= wb_we;
      end
    end
  end

  // Read data
  always_ff @(posedge clk) begin
    if (state == ISSUE && !vdp_q) dat_q <= '0;
    else if (state == WAIT_DONE && host.done) dat_q <= host.rdata;
  end

  assign host.req   = (state == ISSUE) && vdp_q;
  assign host.we    = we_q;
  assign host.ctrl  = ctrl_q;
  assign host.wdata = wb_dat_i;  // Held by the master until ack

  assign wb_ack   = (state == ACK);
  assign wb_dat_o = dat_q;

endmodule : vdp_bus_port

/* logic/vdp_mem_if.sv */
`timescale 1ns/100ps

interface vdp_mem_if;

  vdp_pkg::vram_adr_t vram_adr;
  logic               vram_we;
  vdp_pkg::byte_t     vram_wdata;
  logic               vram_re;
  vdp_pkg::byte_t     vram_rdata;    // One cycle after vram_re
  vdp_pkg::cram_adr_t cram_adr;
  logic               cram_we;
  vdp_pkg::color_t    cram_wdata;
  logic [3:0]         backdrop_idx;  // Low nibble of register 7

  modport engine (
    output vram_adr, vram_we, vram_wdata, vram_re,
    output cram_adr, cram_we, cram_wdata, backdrop_idx,
    input  vram_rdata
  );

  modport vram (input vram_adr, vram_we, vram_wdata, vram_re, output vram_rdata);

  modport palette (input cram_adr, cram_we, cram_wdata, backdrop_idx);

endinterface : vdp_mem_if

/* logic/vdp_host_if.sv */
`timescale 1ns/100ps

// Request/reply link from the bus port to the command engine.
// One request in flight at a time
interface vdp_host_if;

  logic           req;    // One-cycle pulse
  logic           we;
  logic           ctrl;   // High for the control port, low for the data port
  vdp_pkg::byte_t wdata;
  logic           done;   // One-cycle pulse
  vdp_pkg::byte_t rdata;  // Valid with done

  modport bus (
    output req, we, ctrl, wdata,
    input  done, rdata
  );

  modport engine (
    input  req, we, ctrl, wdata,
    output done, rdata
  );

endinterface : vdp_host_if

/* logic/vdp_pkg.sv */
package vdp_pkg;

  // --------------------------------------------------------------------------
  // Widths
  // --------------------------------------------------------------------------
  typedef logic [7:0]  byte_t;      // Bus data byte
  typedef logic [7:0]  io_adr_t;    // CPU I/O port address
  typedef logic [13:0] vram_adr_t;  // 16K VRAM
  typedef logic [4:0]  cram_adr_t;  // 32 palette entries
  typedef logic [5:0]  color_t;     // BBGGRR
  typedef logic [3:0]  channel_t;   // One RGB output channel
  typedef logic [3:0]  reg_idx_t;

  // --------------------------------------------------------------------------
  // Port map and register indices
  // --------------------------------------------------------------------------
  parameter io_adr_t DATA_PORT_ADR = 8'hBE;
  parameter io_adr_t CTRL_PORT_ADR = 8'hBF;

  parameter reg_idx_t BACKDROP_REG = 4'd7;

  // Backdrop always comes from the sprite half of CRAM
  parameter logic BACKDROP_BANK = 1'b1;

  // Second control byte, bits 7:6
  typedef enum logic [1:0] {
    OP_VRAM_READ  = 2'd0,
    OP_VRAM_WRITE = 2'd1,
    OP_REG_WRITE  = 2'd2,
    OP_CRAM_WRITE = 2'd3
  } cmd_op_t;

endpackage : vdp_pkg
